//--- include/dio_defines.svh
// file-transfer port constants for address width, start address and directory-entry offsets
`ifndef DIO_DEFINES_SVH
`define DIO_DEFINES_SVH

// width of ioctl_addr
// 25 bits covers a 32 MB target memory
`define DIO_ADDR_W 25

// every download and upload starts here
`define DIO_START_ADDR 25'h0000000

// FAT directory entry layout as sent by the I/O controller
// 8.3 name occupies bytes 0..10, extension is bytes 8..10
`define DIO_INFO_EXT_OFS 8
// extension bytes, most significant first
`define DIO_INFO_EXT_LEN 3

// file size field at the tail of the 32-byte entry
`define DIO_INFO_SIZE_OFS 28
// size bytes, little endian on the wire
`define DIO_INFO_SIZE_LEN 4

`endif

//--- design/dio_pkg.sv
// shared command codes and packed types for the file-transfer port
`include "dio_defines.svh"

package dio_pkg;

	// command byte at the head of each frame
	typedef enum logic [7:0] {
		// download start (bit 0 set) or end (bit 0 clear)
		file_tx     = 8'h53,
		// download payload bytes
		file_tx_dat = 8'h54,
		// menu index of the selected file
		file_index  = 8'h55,
		// FAT directory entry of the selected file
		file_info   = 8'h56,
		// upload start or end, same bit 0 rule as file_tx
		file_rx     = 8'h57,
		// upload payload bytes, read back on SPI_DO
		file_rx_dat = 8'h58
	} dio_cmd_e;

	// transfer address into the target memory
	typedef logic [`DIO_ADDR_W-1:0] dio_addr_t;

	// current byte and its bit timing as seen by the receiver
	typedef struct packed {
		// frame command, valid after the command byte
		dio_cmd_e   cmd;
		// stored seven bits plus the live input bit
		logic [7:0] data;
		// payload byte number in the frame, sticks at 63
		logic [5:0] idx;
		// payload byte completes on this edge
		logic       done;
		// first bit of a payload byte is being sampled
		logic       first;
		// last bit of any byte, command byte included
		logic       last_bit;
	} dio_byte_t;

	// fields pulled out of the directory entry
	typedef struct packed {
		logic [23:0] ext;
		logic [31:0] size;
	} dio_file_info_t;

endpackage

//--- design/dio_spi_rx.sv
// serial receiver for the file-transfer port, framing bits into bytes with timing strobes
module dio_spi_rx (
	input  logic               SPI_SCK,
	input  logic               SPI_SS2,
	input  logic               SPI_DI,
	output dio_pkg::dio_byte_t rx_byte
);

	// first seven bits of the byte in flight
	// the eighth bit is taken live from SPI_DI
	logic [6:0] sbuf;
	// 0..7 for the command byte, then 8..15 for every payload byte
	logic [3:0] bit_cnt;
	// command of the current frame
	dio_pkg::dio_cmd_e cmd_q;
	// payload bytes completed so far in this frame
	logic [5:0] byte_cnt;

	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			sbuf     <= '0;
			bit_cnt  <= '0;
			cmd_q    <= dio_pkg::dio_cmd_e'(8'h00);
			byte_cnt <= '0;
		end else begin
			sbuf <= {sbuf[5:0], SPI_DI};

			// wrap back to the payload range, never to the command byte
			if (bit_cnt == 4'd15) begin
				bit_cnt <= 4'd8;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end

			// command byte finishes on bit 7
			if (bit_cnt == 4'd7) begin
				cmd_q <= dio_pkg::dio_cmd_e'({sbuf, SPI_DI});
			end

			// saturate so long data frames keep idx at 63
			if (bit_cnt == 4'd15 && byte_cnt != 6'd63) begin
				byte_cnt <= byte_cnt + 6'd1;
			end
		end
	end

	// strobes are valid for the cycle in which the named bit is sampled
	always_comb begin
		rx_byte.cmd      = cmd_q;
		rx_byte.data     = {sbuf, SPI_DI};
		rx_byte.idx      = byte_cnt;
		rx_byte.done     = !SPI_SS2 && (bit_cnt == 4'd15);
		rx_byte.first    = !SPI_SS2 && (bit_cnt == 4'd8);
		// bit 7 of the command byte or bit 15 of a payload byte
		rx_byte.last_bit = !SPI_SS2 && (bit_cnt[2:0] == 3'd7);
	end

	// a byte cannot both start and end in one cycle
	done_first_excl_a: assert property (
		@(posedge SPI_SCK) disable iff (SPI_SS2)
		!(rx_byte.done && rx_byte.first)
	);

endmodule

//--- design/dio_spi_tx.sv
// serial transmitter returning memory bytes on SPI_DO for uploads
module dio_spi_tx (
	input  logic               SPI_SCK,
	input  logic               SPI_SS2,
	input  dio_pkg::dio_byte_t rx_byte,
	input  logic [7:0]         ioctl_din,
	output logic               SPI_DO
);

	// outgoing byte, MSB is on the wire
	logic [7:0] shreg;

	// data changes on the falling edge so the host samples it on the rising one
	always_ff @(negedge SPI_SCK) begin
		if (rx_byte.last_bit) begin
			// fetch the byte at the current address one bit ahead of the
			// next payload byte, its MSB goes out right away
			shreg <= ioctl_din;
		end else begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	// release the line while the port is not selected
	assign SPI_DO = SPI_SS2 ? 1'bz : shreg[7];

endmodule

//--- design/dio_info_capture.sv
// picks the extension and size fields out of a streamed FAT directory entry
`include "dio_defines.svh"

module dio_info_capture (
	input  logic                    SPI_SCK,
	input  logic                    info_en,
	input  dio_pkg::dio_byte_t      rx_byte,
	output dio_pkg::dio_file_info_t file_info
);

	// kept across frames, zero after configuration
	dio_pkg::dio_file_info_t info_q = '0;

	// byte position relative to each field
	logic [5:0] ext_rel;
	logic [5:0] size_rel;
	logic       ext_hit;
	logic       size_hit;

	assign ext_rel  = rx_byte.idx - 6'(`DIO_INFO_EXT_OFS);
	assign size_rel = rx_byte.idx - 6'(`DIO_INFO_SIZE_OFS);

	// unsigned wrap makes bytes before the field fail the range check too
	assign ext_hit  = (ext_rel < 6'(`DIO_INFO_EXT_LEN));
	assign size_hit = (size_rel < 6'(`DIO_INFO_SIZE_LEN));

	always_ff @(posedge SPI_SCK) begin
		if (info_en && rx_byte.done) begin
			if (ext_hit) begin
				// extension arrives most significant byte first
				info_q.ext[{2'd2 - ext_rel[1:0], 3'b000} +: 8] <= rx_byte.data;
			end
			if (size_hit) begin
				// size arrives least significant byte first
				info_q.size[{size_rel[1:0], 3'b000} +: 8] <= rx_byte.data;
			end
			// name, attributes, timestamps and cluster bytes are dropped
		end
	end

	assign file_info = info_q;

endmodule

//--- design/dio_addr_gen.sv
// transfer address counter, reloaded at session start and stepped per byte
`include "dio_defines.svh"

module dio_addr_gen (
	input  logic                   SPI_SCK,
	input  logic                   restart,
	input  logic                   advance,
	output logic [`DIO_ADDR_W-1:0] addr
);

	// survives deselect so split transfers continue where they stopped
	dio_pkg::dio_addr_t addr_q = '0;
	dio_pkg::dio_addr_t addr_next;

	always_comb begin
		// a new session takes priority over a pending step
		if (restart) begin
			addr_next = `DIO_START_ADDR;
		end else if (advance) begin
			addr_next = addr_q + 1'b1;
		end else begin
			addr_next = addr_q;
		end
	end

	always_ff @(posedge SPI_SCK) begin
		addr_q <= addr_next;
	end

	assign addr = addr_q;

	// a transfer longer than the address space is a host error
	no_wrap_a: assert property (
		@(posedge SPI_SCK)
		(advance && !restart) |-> (addr_q != '1)
	);

endmodule

//--- design/dio_ctrl.sv
// command decode, session flags, menu index and memory write strobe
module dio_ctrl (
	input  logic               SPI_SCK,
	input  logic               SPI_SS2,
	input  dio_pkg::dio_byte_t rx_byte,
	output logic               restart,
	output logic               advance,
	output logic               info_en,
	output logic               ioctl_download,
	output logic               ioctl_upload,
	output logic [7:0]         ioctl_index,
	output logic               ioctl_wr,
	output logic [7:0]         ioctl_dout
);

	// command decode of the current frame
	logic is_tx;
	logic is_tx_dat;
	logic is_index;
	logic is_rx;
	logic is_rx_dat;

	// session state, only changed by commands
	logic       download_q = 1'b0;
	logic       upload_q   = 1'b0;
	logic [7:0] index_q    = 8'h00;

	// write strobe and its data
	logic       wr_q;
	logic [7:0] dout_q;
	logic       wr_take;

	assign is_tx     = (rx_byte.cmd == dio_pkg::file_tx);
	assign is_tx_dat = (rx_byte.cmd == dio_pkg::file_tx_dat);
	assign is_index  = (rx_byte.cmd == dio_pkg::file_index);
	assign is_rx     = (rx_byte.cmd == dio_pkg::file_rx);
	assign is_rx_dat = (rx_byte.cmd == dio_pkg::file_rx_dat);

	// bit 0 of the session byte selects start over end
	assign restart = rx_byte.done && (is_tx || is_rx) && rx_byte.data[0];

	// data bytes are only written inside a download session
	assign wr_take = rx_byte.done && is_tx_dat && download_q;

	always_ff @(posedge SPI_SCK) begin
		if (rx_byte.done) begin
			if (is_tx) begin
				download_q <= rx_byte.data[0];
				// a new download ends any upload
				if (rx_byte.data[0]) begin
					upload_q <= 1'b0;
				end
			end
			if (is_rx) begin
				upload_q <= rx_byte.data[0];
				if (rx_byte.data[0]) begin
					download_q <= 1'b0;
				end
			end
			if (is_index) begin
				index_q <= rx_byte.data;
			end
		end
	end

	// strobe lasts one cycle, deselect drops it at once
	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= wr_take;
		end
	end

	always_ff @(posedge SPI_SCK) begin
		if (wr_take) begin
			dout_q <= rx_byte.data;
		end
	end

	// download steps after the write cycle, upload steps as each
	// payload byte begins so the transmitter sees the next byte
	assign advance = wr_q || (rx_byte.first && is_rx_dat && upload_q);

	assign info_en        = (rx_byte.cmd == dio_pkg::file_info);
	assign ioctl_download = download_q;
	assign ioctl_upload   = upload_q;
	assign ioctl_index    = index_q;
	assign ioctl_wr       = wr_q;
	assign ioctl_dout     = dout_q;

	// memory is only written during a download session
	wr_in_download_a: assert property (
		@(posedge SPI_SCK) ioctl_wr |-> ioctl_download
	);

	// the two sessions exclude each other
	one_session_a: assert property (
		@(posedge SPI_SCK) !(ioctl_download && ioctl_upload)
	);

endmodule

//--- design/data_io.sv
// file-transfer port top, moving ROM images and file info between the I/O controller and core
`include "dio_defines.svh"

module data_io (
	input  logic                    SPI_SCK,
	input  logic                    SPI_SS2,
	input  logic                    SPI_DI,
	output logic                    SPI_DO,
	output logic                    ioctl_download,
	output logic                    ioctl_upload,
	output logic                    ioctl_wr,
	output logic [7:0]              ioctl_index,
	output logic [`DIO_ADDR_W-1:0]  ioctl_addr,
	output logic [7:0]              ioctl_dout,
	input  logic [7:0]              ioctl_din,
	output dio_pkg::dio_file_info_t ioctl_fileinfo
);

	// current byte and bit strobes from the receiver
	dio_pkg::dio_byte_t rx_byte;
	// address control from the command decoder
	logic restart;
	logic advance;
	// directory entry frame in progress
	logic info_en;

	dio_spi_rx dio_spi_rx_i (
		.SPI_SCK (SPI_SCK),
		.SPI_SS2 (SPI_SS2),
		.SPI_DI  (SPI_DI),
		.rx_byte (rx_byte)
	);

	// upload data back to the controller
	dio_spi_tx dio_spi_tx_i (
		.SPI_SCK   (SPI_SCK),
		.SPI_SS2   (SPI_SS2),
		.rx_byte   (rx_byte),
		.ioctl_din (ioctl_din),
		.SPI_DO    (SPI_DO)
	);

	dio_info_capture dio_info_capture_i (
		.SPI_SCK   (SPI_SCK),
		.info_en   (info_en),
		.rx_byte   (rx_byte),
		.file_info (ioctl_fileinfo)
	);

	dio_addr_gen dio_addr_gen_i (
		.SPI_SCK (SPI_SCK),
		.restart (restart),
		.advance (advance),
		.addr    (ioctl_addr)
	);

	dio_ctrl dio_ctrl_i (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.rx_byte        (rx_byte),
		.restart        (restart),
		.advance        (advance),
		.info_en        (info_en),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

//--- dv/data_io_tb.sv
// testbench for the file-transfer port, driving SPI frames and checking memory and register effects
`include "dio_defines.svh"

module data_io_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// longest random data frame in bytes
	localparam int max_data_len = 40;
	// tx start, two data, tx end, idle data, index, info, rx start, rx data, rx end
	localparam int n_frames     = 10;
	localparam int max_payload  = 1 + 2 * max_data_len + 1 + 4 + 1 + 32 + 1 + max_data_len + 1;
	localparam int max_bits     = 8 * (n_frames + max_payload);
	localparam int cycle_limit  = 4 * max_bits + 1000;

	logic                    SPI_SCK;
	logic                    SPI_SS2;
	logic                    SPI_DI;
	wire                     SPI_DO;
	logic                    ioctl_download;
	logic                    ioctl_upload;
	logic                    ioctl_wr;
	logic [7:0]              ioctl_index;
	logic [`DIO_ADDR_W-1:0]  ioctl_addr;
	logic [7:0]              ioctl_dout;
	logic [7:0]              ioctl_din;
	dio_pkg::dio_file_info_t ioctl_fileinfo;

	// memory seen by the DUT, written only from ioctl_wr
	logic [7:0] model_mem [0:255];
	// expected memory contents, built from the bytes the host sends
	logic [7:0] exp_mem [0:255];
	// host side byte buffers for one frame
	logic [7:0] tx_buf [0:63];
	logic [7:0] rx_buf [0:63];

	logic [31:0] rng_state;
	// write pulses seen and download bytes sent so far
	int wr_count  = 0;
	int dl_total  = 0;
	int cycle_cnt = 0;

	data_io data_io_i (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_DI         (SPI_DI),
		.SPI_DO         (SPI_DO),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_din      (ioctl_din),
		.ioctl_fileinfo (ioctl_fileinfo)
	);

	// 100 ns period
	always #50 SPI_SCK = ~SPI_SCK;

	// combinational read port, low address bits only
	assign ioctl_din = model_mem[ioctl_addr[7:0]];

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
	endtask

	// xorshift32 step
	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	function automatic logic [7:0] random_byte();
		return 8'(next_random() >> 8);
	endfunction

	function automatic int random_len(input int max_len);
		return 1 + int'(next_random() % max_len);
	endfunction

	// multiplier is odd so every address bit changes the pattern
	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 29 + 107);
	endfunction

	// memory slot of transfer byte k
	function automatic logic [7:0] mem_index(input int k);
		return 8'(`DIO_START_ADDR + k);
	endfunction

	// one byte MSB first, called 5 ns after a rising edge
	task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			SPI_DI = tx[i];
			@(posedge SPI_SCK);
			// SPI_DO moves on the falling edge, steady here
			rx[i] = SPI_DO;
			#5;
		end
	endtask

	// command byte, len payload bytes from tx_buf, answers into rx_buf
	task automatic send_frame(input logic [7:0] cmd, input int len);
		logic [7:0] rx;
		logic       msb;
		@(posedge SPI_SCK);
		#5;
		SPI_SS2 = 1'b0;
		xfer_byte(cmd, rx);
		for (int i = 0; i < len; i++) begin
			// a returned byte leads by one bit, its MSB comes with the last bit before
			msb = rx[0];
			xfer_byte(tx_buf[i], rx);
			rx_buf[i] = {msb, rx[7:1]};
		end
		// trailing clock lets the last write strobe finish
		@(posedge SPI_SCK);
		#5;
		SPI_SS2 = 1'b1;
		SPI_DI  = 1'b0;
		// deselected for two cycles, the next start adds the second
		@(posedge SPI_SCK);
	endtask

	task automatic send_download_frame(input int len);
		for (int i = 0; i < len; i++) begin
			tx_buf[i] = random_byte();
			exp_mem[mem_index(dl_total + i)] = tx_buf[i];
		end
		dl_total = dl_total + len;
		send_frame(dio_pkg::file_tx_dat, len);
	endtask

	// write strobe and idle line checks, sampled mid cycle
	always @(negedge SPI_SCK) begin
		if (SPI_SS2) begin
			assert (SPI_DO === 1'bz) else
				abort_run("SPI_DO is driven while the port is deselected");
			assert (ioctl_wr === 1'b0) else
				abort_run("ioctl_wr is high while the port is deselected");
		end
		if (ioctl_wr === 1'b1) begin
			assert (wr_count < dl_total) else
				abort_run("ioctl_wr pulsed with no download byte outstanding");
			check_value("ioctl_addr", `DIO_START_ADDR + wr_count, ioctl_addr);
			check_value("ioctl_dout", exp_mem[mem_index(wr_count)], ioctl_dout);
			model_mem[ioctl_addr[7:0]] = ioctl_dout;
			wr_count++;
		end
	end

	always @(posedge SPI_SCK) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			abort_run($sformatf("timeout after %0d cycles, the test sequence did not finish",
				cycle_cnt));
		end
	end

	initial begin
		int         up_len;
		logic [7:0] exp_index;
		logic [23:0] exp_ext;
		logic [31:0] exp_size;

		SPI_SCK   = 1'b0;
		SPI_SS2   = 1'b1;
		SPI_DI    = 1'b0;
		rng_state = 32'h76219284;
		for (int a = 0; a < 256; a++) begin
			model_mem[a] = fill_byte(a);
			exp_mem[a]   = fill_byte(a);
		end
		repeat (8) @(posedge SPI_SCK);

		// download session over two data frames
		tx_buf[0] = random_byte() | 8'h01;
		send_frame(dio_pkg::file_tx, 1);
		check_value("ioctl_download", 1, ioctl_download);
		check_value("ioctl_upload", 0, ioctl_upload);
		send_download_frame(random_len(max_data_len));
		send_download_frame(random_len(max_data_len));
		check_value("ioctl_download", 1, ioctl_download);
		check_value("ioctl_wr pulse count", dl_total, wr_count);
		tx_buf[0] = random_byte() & 8'hFE;
		send_frame(dio_pkg::file_tx, 1);
		check_value("ioctl_download", 0, ioctl_download);

		// data outside a session must not write
		for (int i = 0; i < 4; i++) begin
			tx_buf[i] = random_byte();
		end
		send_frame(dio_pkg::file_tx_dat, 4);
		check_value("ioctl_wr pulse count", dl_total, wr_count);

		// menu index
		exp_index = random_byte();
		tx_buf[0] = exp_index;
		send_frame(dio_pkg::file_index, 1);
		check_value("ioctl_index", exp_index, ioctl_index);

		// directory entry, 32 bytes
		for (int i = 0; i < 32; i++) begin
			tx_buf[i] = random_byte();
		end
		send_frame(dio_pkg::file_info, 32);
		exp_ext = {tx_buf[`DIO_INFO_EXT_OFS], tx_buf[`DIO_INFO_EXT_OFS + 1],
			tx_buf[`DIO_INFO_EXT_OFS + 2]};
		exp_size = {tx_buf[`DIO_INFO_SIZE_OFS + 3], tx_buf[`DIO_INFO_SIZE_OFS + 2],
			tx_buf[`DIO_INFO_SIZE_OFS + 1], tx_buf[`DIO_INFO_SIZE_OFS]};
		check_value("ioctl_fileinfo.ext", exp_ext, ioctl_fileinfo.ext);
		check_value("ioctl_fileinfo.size", exp_size, ioctl_fileinfo.size);
		check_value("ioctl_index", exp_index, ioctl_index);

		// upload session, bytes come back from the model memory
		tx_buf[0] = random_byte() | 8'h01;
		send_frame(dio_pkg::file_rx, 1);
		check_value("ioctl_upload", 1, ioctl_upload);
		check_value("ioctl_download", 0, ioctl_download);
		up_len = random_len(max_data_len);
		for (int i = 0; i < up_len; i++) begin
			tx_buf[i] = random_byte();
		end
		send_frame(dio_pkg::file_rx_dat, up_len);
		for (int n = 0; n < up_len; n++) begin
			check_value($sformatf("SPI_DO byte %0d", n), exp_mem[mem_index(n)], rx_buf[n]);
		end
		tx_buf[0] = random_byte() & 8'hFE;
		send_frame(dio_pkg::file_rx, 1);
		check_value("ioctl_upload", 0, ioctl_upload);
		check_value("ioctl_wr pulse count", dl_total, wr_count);
		check_value("ioctl_index", exp_index, ioctl_index);

		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
design/dio_pkg.sv
design/dio_spi_rx.sv
design/dio_spi_tx.sv
design/dio_info_capture.sv
design/dio_addr_gen.sv
design/dio_ctrl.sv
design/data_io.sv
dv/data_io_tb.sv

//--- Bender.yml
package:
  name: data_io

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/dio_pkg.sv
      - design/dio_spi_rx.sv
      - design/dio_spi_tx.sv
      - design/dio_info_capture.sv
      - design/dio_addr_gen.sv
      - design/dio_ctrl.sv
      - design/data_io.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/data_io_tb.sv
